// File: filelist.f
isa_pkg.sv
ctrl_pkg.sv
alu.sv
instr_decoder.sv
program_counter.sv
cpu_datapath.sv
cpu_core.sv
tb_clk_gen.sv
tb_cpu_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cpu_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_cpu_core
./obj_dir/Vtb_cpu_core | tee sim.log

if grep -q "^=== PASS ===$" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: tb_cpu_core.sv
module tb_cpu_core
	import isa_pkg::*;
();

	localparam int num_prog = 60;	// generated instructions
	localparam int num_rec  = 70;	// plus the filler no-ops
	localparam int num_ops  = 14;
	localparam int clk_per  = 10;
	localparam int timeout  = num_prog * 4 * clk_per + 200;	// every instruction at its longest
	localparam logic [data_w-1:0] nop_op = 8'hea;	// not decoded, runs as a two-cycle no-op
	localparam logic [data_w-1:0] op_list [num_ops] = '{ADC_IMM, SBC_IMM, ADC_ZPG, ADC_ABS,
		SEC, CLC, INX, INY, DEX, DEY, TAX, TXA, TAY, TYA};

	logic              clk_ph2, rst;
	logic [data_w-1:0] din;
	logic [addr_w-1:0] addr;
	logic              sync;
	logic [data_w-1:0] a, x, y, p;

	logic [data_w-1:0] mem [4096];	// mirrored on the low 12 address bits
	logic [addr_w-1:0] addr_q;	// address taken at the last rising edge
	logic [31:0]       lcg_state;
	logic [data_w-1:0] m_a, m_x, m_y;	// reference model registers
	logic              m_n, m_v, m_z, m_c;
	logic [addr_w-1:0] exp_pc [num_rec];	// fetch address per instruction
	logic [addr_w-1:0] exp_daddr [num_rec];
	int                exp_doff [num_rec];	// data cycle offset from sync, 0 for none
	int                exp_cyc [num_rec];	// cycles until the next sync
	logic [31:0]       exp_regs [num_rec];	// {a, x, y, p} after the instruction
	int                clk_cnt, n_sync, since_sync, err_cnt;

	tb_clk_gen u_tb_clk_gen (
		.clk_ph2 (clk_ph2),
		.rst     (rst)
	);

	cpu_core u_cpu_core (
		.clk_ph2 (clk_ph2),
		.rst     (rst),
		.din     (din),
		.addr    (addr),
		.sync    (sync),
		.a       (a),
		.x       (x),
		.y       (y),
		.p       (p)
	);

	//////////////////////////////////////////////////
	// memory and cycle bookkeeping
	//////////////////////////////////////////////////

	always @(posedge clk_ph2)
		addr_q <= addr;
	always @(negedge clk_ph2)
		din <= mem[addr_q[11:0]];	// stable across the next rising edge

	always @(posedge clk_ph2) begin
		clk_cnt <= clk_cnt + 1;
		if (!rst) begin
			n_sync     <= 0;
			since_sync <= 0;
		end else if (sync) begin
			n_sync     <= n_sync + 1;	// fetches seen so far
			since_sync <= 1;
		end else begin
			since_sync <= since_sync + 1;
		end
	end

	//////////////////////////////////////////////////
	// program generator and reference model
	//////////////////////////////////////////////////

	function automatic logic [data_w-1:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];	// middle bits, the low ones repeat quickly
	endfunction

	function automatic logic [11:0] mirror_addr(input logic [addr_w-1:0] base, input int off);
		logic [addr_w-1:0] t;
		t = base + addr_w'(off);
		return t[11:0];
	endfunction

	task automatic set_nz(input logic [data_w-1:0] r);
		m_n = r[data_w-1];
		m_z = (r == 8'h00);
	endtask

	task automatic add_with_carry(input logic [data_w-1:0] m);
		logic [data_w:0] s;
		s   = {1'b0, m_a} + {1'b0, m} + {8'h00, m_c};
		m_v = (m_a[7] == m[7]) && (s[7] != m_a[7]);	// same-sign inputs, other-sign result
		m_c = s[8];
		m_a = s[7:0];
		set_nz(m_a);
	endtask

	function automatic logic [data_w-1:0] status_byte();
		logic [data_w-1:0] b;
		b         = '0;
		b[flag_n] = m_n;
		b[flag_v] = m_v;
		b[flag_z] = m_z;
		b[flag_c] = m_c;
		return b;
	endfunction

	task automatic build_program();
		logic [addr_w-1:0] pc_m;
		logic [data_w-1:0] opc, b1;
		int                len;
		lcg_state = 32'd13;
		for (int i = 0; i < 4096; i++)
			mem[i] = lcg_next();	// zero page and page 03 data come from here
		{m_a, m_x, m_y}      = '0;	// register state after reset
		{m_n, m_v, m_z, m_c} = '0;
		pc_m = reset_pc;
		for (int i = 0; i < num_rec; i++) begin
			if (i < num_ops)
				opc = op_list[(i * 5) % num_ops];	// stride 5 visits every opcode first
			else if (i < num_prog)
				opc = op_list[int'(lcg_next()) % num_ops];
			else
				opc = nop_op;
			b1 = lcg_next();
			mem[mirror_addr(pc_m, 0)] = opc;
			exp_pc[i]    = pc_m;
			exp_daddr[i] = '0;
			exp_doff[i]  = 0;
			exp_cyc[i]   = 2;
			len          = 1;
			case (opc)
				ADC_IMM, SBC_IMM: begin
					mem[mirror_addr(pc_m, 1)] = b1;
					len = 2;
					add_with_carry((opc == SBC_IMM) ? ~b1 : b1);	// subtract adds the inverse
				end
				ADC_ZPG: begin
					mem[mirror_addr(pc_m, 1)] = b1;
					exp_daddr[i] = {8'h00, b1};
					exp_doff[i]  = 2;
					exp_cyc[i]   = 3;
					len          = 2;
					add_with_carry(mem[{4'h0, b1}]);
				end
				ADC_ABS: begin
					mem[mirror_addr(pc_m, 1)] = b1;
					mem[mirror_addr(pc_m, 2)] = 8'h03;	// data page 03
					exp_daddr[i] = {8'h03, b1};
					exp_doff[i]  = 3;
					exp_cyc[i]   = 4;
					len          = 3;
					add_with_carry(mem[{4'h3, b1}]);
				end
				SEC: m_c = 1'b1;
				CLC: m_c = 1'b0;
				INX, DEX: begin
					m_x = (opc == INX) ? m_x + 8'd1 : m_x - 8'd1;
					set_nz(m_x);
				end
				INY, DEY: begin
					m_y = (opc == INY) ? m_y + 8'd1 : m_y - 8'd1;
					set_nz(m_y);
				end
				TAX, TAY: begin
					if (opc == TAX)
						m_x = m_a;
					else
						m_y = m_a;
					set_nz(m_a);
				end
				TXA, TYA: begin
					m_a = (opc == TXA) ? m_x : m_y;
					set_nz(m_a);
				end
				default: ;	// filler, nothing changes
			endcase
			exp_regs[i] = {m_a, m_x, m_y, status_byte()};
			pc_m = pc_m + addr_w'(len);
		end
	endtask

	task automatic report_error(input string msg);
		err_cnt++;
		$display("ERR t=%0t %s", $time, msg);
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first error");
	endtask

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_rst_sync: assert property (@(posedge clk_ph2) (!rst && clk_cnt > 0) |-> !sync)
		else report_error("sync high during reset");
	a_rst_exit: assert property (@(posedge clk_ph2) $rose(rst) |-> !sync)
		else report_error("sync high in the first cycle after reset");
	a_boot: assert property (@(posedge clk_ph2) $rose(rst) |=> (sync && addr == reset_pc))
		else report_error($sformatf("first fetch at %h, expected %h", $sampled(addr), reset_pc));

	a_fetch_addr: assert property (@(posedge clk_ph2)
		(rst && sync && n_sync < num_rec) |-> (addr == exp_pc[n_sync]))
		else report_error($sformatf("fetch %0d at %h, expected %h", $sampled(n_sync),
			$sampled(addr), exp_pc[$sampled(n_sync)]));

	a_sync_gap: assert property (@(posedge clk_ph2)
		(rst && sync && n_sync >= 1 && n_sync <= num_rec) |-> (since_sync == exp_cyc[n_sync - 1]))
		else report_error($sformatf("instr %0d took %0d cycles, expected %0d", $sampled(n_sync) - 1,
			$sampled(since_sync), exp_cyc[$sampled(n_sync) - 1]));

	a_sync_late: assert property (@(posedge clk_ph2)
		(rst && !sync && n_sync >= 1 && n_sync <= num_rec) |-> (since_sync < exp_cyc[n_sync - 1]))
		else report_error($sformatf("instr %0d still running after %0d cycles",
			$sampled(n_sync) - 1, $sampled(since_sync)));

	a_data_addr: assert property (@(posedge clk_ph2)
		(rst && !sync && n_sync >= 1 && n_sync <= num_rec && since_sync == exp_doff[n_sync - 1])
		|-> (addr == exp_daddr[n_sync - 1]))
		else report_error($sformatf("instr %0d data read at %h, expected %h", $sampled(n_sync) - 1,
			$sampled(addr), exp_daddr[$sampled(n_sync) - 1]));

	// result of the previous instruction shows up right after the next fetch
	a_writeback: assert property (@(posedge clk_ph2)
		(rst && !sync && since_sync == 1 && n_sync >= 2 && n_sync <= num_rec + 1)
		|-> ({a, x, y, p} == exp_regs[n_sync - 2]))
		else report_error($sformatf("instr %0d a x y p = %h %h %h %h, expected %h",
			$sampled(n_sync) - 2, $sampled(a), $sampled(x), $sampled(y), $sampled(p),
			exp_regs[$sampled(n_sync) - 2]));

	//////////////////////////////////////////////////
	// run control
	//////////////////////////////////////////////////

	initial begin
		din = '0;
		build_program();
		wait (rst);
		wait (n_sync >= num_prog + 2);	// last generated result is checked by now
		repeat (2) @(posedge clk_ph2);
		if (err_cnt == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "checks failed");
		end
	end

	initial begin
		#(timeout);
		$display("timeout: the core did not reach the end of the program in time");
		$display("=== FAIL ===");
		$fatal(1, "watchdog expired");
	end

endmodule

// File: tb_clk_gen.sv
module tb_clk_gen (
	output logic clk_ph2,
	output logic rst
);

	localparam int half_per   = 5;	// 10 unit period
	localparam int rst_cycles = 4;

	initial begin
		clk_ph2 = 1'b0;
		forever #half_per clk_ph2 = ~clk_ph2;
	end

	initial begin
		rst = 1'b0;	// active low, held from time zero
		repeat (rst_cycles) @(posedge clk_ph2);
		@(negedge clk_ph2);	// release away from the sampling edge
		rst = 1'b1;
	end

endmodule

// File: cpu_core.sv
module cpu_core
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic              clk_ph2,
	input  logic              rst,
	input  logic [data_w-1:0] din,	// read data, one cycle after addr
	output logic [addr_w-1:0] addr,
	output logic              sync,	// opcode fetch cycle
	output logic [data_w-1:0] a,
	output logic [data_w-1:0] x,
	output logic [data_w-1:0] y,
	output logic [data_w-1:0] p
);

	logic              pc_inc, lat_addr_lo;
	logic [addr_w-1:0] pc;
	sb_src_e           sb_src;
	sb_dst_e           sb_dst;
	alu_a_e            alu_a;
	alu_b_e            alu_b;
	alu_cin_e          alu_cin;
	ab_src_e           ab_src;
	flag_op_e          flag_op;

	//////////////////////////////////////////////////
	// control
	//////////////////////////////////////////////////

	instr_decoder u_instr_decoder (
		.clk_ph2     (clk_ph2),
		.rst         (rst),
		.din         (din),
		.sync        (sync),
		.pc_inc      (pc_inc),
		.lat_addr_lo (lat_addr_lo),
		.sb_src      (sb_src),
		.sb_dst      (sb_dst),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_cin     (alu_cin),
		.ab_src      (ab_src),
		.flag_op     (flag_op)
	);

	program_counter u_program_counter (
		.clk_ph2 (clk_ph2),
		.rst     (rst),
		.pc_inc  (pc_inc),
		.pc      (pc)
	);

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	cpu_datapath u_cpu_datapath (
		.clk_ph2     (clk_ph2),
		.rst         (rst),
		.din         (din),
		.pc          (pc),
		.sb_src      (sb_src),
		.sb_dst      (sb_dst),
		.alu_a       (alu_a),
		.alu_b       (alu_b),
		.alu_cin     (alu_cin),
		.ab_src      (ab_src),
		.flag_op     (flag_op),
		.lat_addr_lo (lat_addr_lo),
		.addr        (addr),
		.a           (a),
		.x           (x),
		.y           (y),
		.p           (p)
	);

endmodule

// File: cpu_datapath.sv
module cpu_datapath
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic              clk_ph2,
	input  logic              rst,
	input  logic [data_w-1:0] din,
	input  logic [addr_w-1:0] pc,
	input  sb_src_e           sb_src,
	input  sb_dst_e           sb_dst,
	input  alu_a_e            alu_a,
	input  alu_b_e            alu_b,
	input  alu_cin_e          alu_cin,
	input  ab_src_e           ab_src,
	input  flag_op_e          flag_op,
	input  logic              lat_addr_lo,
	output logic [addr_w-1:0] addr,
	output logic [data_w-1:0] a,
	output logic [data_w-1:0] x,
	output logic [data_w-1:0] y,
	output logic [data_w-1:0] p	// status byte
);

	logic [data_w-1:0] sb, db;	// internal buses
	logic [data_w-1:0] adl, adh;	// address low / high buses
	logic [data_w-1:0] dl;	// data latch, last byte read
	logic [data_w-1:0] add_hold;	// adder hold, absolute low byte
	logic [data_w-1:0] sum;
	logic              carry, ovf;
	logic              n_f, v_f, z_f, c_f;

	//////////////////////////////////////////////////
	// buses
	//////////////////////////////////////////////////

	assign db = din;	// memory byte straight onto the data bus

	always_comb begin
		case (sb_src)
			SB_AC:   sb = a;
			SB_X:    sb = x;
			SB_Y:    sb = y;
			SB_ADD:  sb = add_hold;
			default: sb = '0;
		endcase
		case (ab_src)
			AB_ZPG: begin	// {00, operand} while the operand is on din
				adh = '0;
				adl = din;
			end
			AB_ABS: begin	// high byte on din, low byte held from last cycle
				adh = din;
				adl = add_hold;
			end
			default: begin
				adh = pc[addr_w-1:data_w];
				adl = pc[data_w-1:0];
			end
		endcase
	end

	assign addr = {adh, adl};

	alu u_alu (
		.sb      (sb),
		.db      (db),
		.adl     (adl),
		.c_flag  (c_f),
		.alu_a   (alu_a),
		.alu_b   (alu_b),
		.alu_cin (alu_cin),
		.sum     (sum),
		.carry   (carry),
		.ovf     (ovf)
	);

	//////////////////////////////////////////////////
	// latches and registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_ph2) begin
		dl <= din;	// holds the opcode during the execute cycle
		if (lat_addr_lo)
			add_hold <= sum;
	end

	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			a   <= '0;
			x   <= '0;
			y   <= '0;
			n_f <= 1'b0;
			v_f <= 1'b0;
			z_f <= 1'b0;
			c_f <= 1'b0;
		end else begin
			case (sb_dst)	// ALU result back to a register
				DST_AC:  a <= sum;
				DST_X:   x <= sum;
				DST_Y:   y <= sum;
				default: ;
			endcase
			case (flag_op)
				FL_NZ, FL_NZCV: begin
					n_f <= sum[data_w-1];
					z_f <= (sum == '0);
					if (flag_op == FL_NZCV) begin
						c_f <= carry;
						v_f <= ovf;
					end
				end
				FL_IR5_C: c_f <= dl[5];	// SEC 38 has bit 5 set, CLC 18 clear
				default:  ;
			endcase
		end
	end

	always_comb begin
		p         = '0;
		p[flag_n] = n_f;
		p[flag_v] = v_f;
		p[flag_z] = z_f;
		p[flag_c] = c_f;
	end

	// held low byte is consumed by the absolute data cycle that follows
	a_abs_lo: assert property (@(posedge clk_ph2) disable iff (!rst)
		lat_addr_lo |=> (ab_src == AB_ABS));

endmodule

// File: program_counter.sv
module program_counter
	import isa_pkg::*;
(
	input  logic              clk_ph2,
	input  logic              rst,
	input  logic              pc_inc,	// step to the next byte
	output logic [addr_w-1:0] pc
);

	//////////////////////////////////////////////////
	// counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_ph2) begin
		if (!rst)
			pc <= reset_pc;	// first opcode address
		else if (pc_inc)
			pc <= pc + 1'b1;	// wraps at 64K
	end

	// pc only moves on an increment request
	a_pc_hold: assert property (@(posedge clk_ph2) disable iff (!rst)
		!pc_inc |=> $stable(pc));

endmodule

// File: instr_decoder.sv
module instr_decoder
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic              clk_ph2,
	input  logic              rst,
	input  logic [data_w-1:0] din,	// memory read data
	output logic              sync,	// opcode fetch on addr this cycle
	output logic              pc_inc,
	output logic              lat_addr_lo,	// hold ALU sum as absolute low byte
	output sb_src_e           sb_src,
	output sb_dst_e           sb_dst,
	output alu_a_e            alu_a,
	output alu_b_e            alu_b,
	output alu_cin_e          alu_cin,
	output ab_src_e           ab_src,
	output flag_op_e          flag_op
);

	cyc_e              cyc, cyc_nxt;	// cycle of the current instruction
	logic [data_w-1:0] ir;	// opcode register, loaded in CYC1
	logic [data_w-1:0] cur_op;
	opcode_e           op;
	logic              multi;	// opcode has an operand byte
	logic              fin;	// last cycle, next one fetches an opcode
	logic              pc_inc_r;

	// next-cycle selects
	logic     nxt_sync, nxt_inc, nxt_lat;
	sb_src_e  nxt_sb_src;
	sb_dst_e  nxt_sb_dst;
	alu_a_e   nxt_alu_a;
	alu_b_e   nxt_alu_b;
	alu_cin_e nxt_alu_cin;
	ab_src_e  nxt_ab_src;
	flag_op_e nxt_flag_op;

	assign cur_op = (cyc == CYC1) ? din : ir;	// opcode is still on din in CYC1
	assign op     = opcode_e'(cur_op);
	assign multi  = op inside {ADC_IMM, SBC_IMM, ADC_ZPG, ADC_ABS};

	// one-byte opcodes read a dummy byte in CYC1 and leave the PC alone
	assign pc_inc = pc_inc_r & ~((cyc == CYC1) & ~multi);

	//////////////////////////////////////////////////
	// cycle table
	//////////////////////////////////////////////////

	always_comb begin
		nxt_sync    = 1'b0;	// everything idle unless a cycle asks for it
		nxt_inc     = 1'b0;
		nxt_lat     = 1'b0;
		nxt_sb_src  = SB_NONE;
		nxt_sb_dst  = DST_NONE;
		nxt_alu_a   = A_ZERO;
		nxt_alu_b   = B_ZERO;
		nxt_alu_cin = CIN_ZERO;
		nxt_ab_src  = AB_PC;
		nxt_flag_op = FL_NONE;
		cyc_nxt     = CYC0;
		fin         = 1'b0;
		case (cyc)
			CYC0: begin	// next: operand or dummy byte at PC
				nxt_inc = 1'b1;
				cyc_nxt = CYC1;
			end
			CYC1: begin
				case (op)
					ADC_ZPG: begin	// next: read data at {00, operand}
						nxt_ab_src = AB_ZPG;
						cyc_nxt    = CYC2;
					end
					ADC_ABS: begin	// next: fetch high byte, low byte through ALU into hold
						nxt_inc   = 1'b1;
						nxt_lat   = 1'b1;
						nxt_alu_b = B_DB;
						cyc_nxt   = CYC2;
					end
					default: fin = 1'b1;	// implied, immediate, unknown
				endcase
			end
			CYC2: begin
				if (op == ADC_ABS) begin	// next: read data at {high, low}
					nxt_ab_src = AB_ABS;
					cyc_nxt    = CYC3;
				end else begin
					fin = 1'b1;
				end
			end
			default: fin = 1'b1;	// CYC3, also the boot path out of reset
		endcase

		// last cycle: fetch next opcode and execute in the same cycle
		if (fin) begin
			nxt_sync = 1'b1;
			nxt_inc  = 1'b1;
			cyc_nxt  = CYC0;
			case (op)
				ADC_IMM, ADC_ZPG, ADC_ABS, SBC_IMM: begin	// A + M + C
					nxt_sb_src  = SB_AC;
					nxt_alu_a   = A_SB;
					nxt_alu_b   = (op == SBC_IMM) ? B_NDB : B_DB;
					nxt_alu_cin = CIN_FLAG;
					nxt_sb_dst  = DST_AC;
					nxt_flag_op = FL_NZCV;
				end
				SEC, CLC: nxt_flag_op = FL_IR5_C;	// bit 5 of the opcode
				INX, DEX, INY, DEY: begin
					nxt_sb_src  = (op == INX || op == DEX) ? SB_X : SB_Y;
					nxt_sb_dst  = (op == INX || op == DEX) ? DST_X : DST_Y;
					nxt_alu_a   = A_SB;
					nxt_alu_b   = (op == DEX || op == DEY) ? B_MINUS_ONE : B_ZERO;
					nxt_alu_cin = (op == INX || op == INY) ? CIN_ONE : CIN_ZERO;
					nxt_flag_op = FL_NZ;
				end
				TAX, TAY, TXA, TYA: begin	// pass source + 0 through the ALU
					nxt_sb_src  = (op == TXA) ? SB_X : (op == TYA) ? SB_Y : SB_AC;
					nxt_sb_dst  = (op == TAX) ? DST_X : (op == TAY) ? DST_Y : DST_AC;
					nxt_alu_a   = A_SB;
					nxt_flag_op = FL_NZ;
				end
				default: ;	// unknown opcode, two-cycle no-op
			endcase
		end
	end

	//////////////////////////////////////////////////
	// state and select registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk_ph2) begin
		if (!rst) begin
			cyc         <= CYC3;	// with a cleared ir this drops into the first fetch
			ir          <= '0;
			sync        <= 1'b0;
			pc_inc_r    <= 1'b0;
			lat_addr_lo <= 1'b0;
			sb_src      <= SB_NONE;
			sb_dst      <= DST_NONE;
			alu_a       <= A_ZERO;
			alu_b       <= B_ZERO;
			alu_cin     <= CIN_ZERO;
			ab_src      <= AB_PC;
			flag_op     <= FL_NONE;
		end else begin
			cyc <= cyc_nxt;
			if (cyc == CYC1)
				ir <= din;	// opcode arrives the cycle after sync
			sync        <= nxt_sync;
			pc_inc_r    <= nxt_inc;
			lat_addr_lo <= nxt_lat;
			sb_src      <= nxt_sb_src;
			sb_dst      <= nxt_sb_dst;
			alu_a       <= nxt_alu_a;
			alu_b       <= nxt_alu_b;
			alu_cin     <= nxt_alu_cin;
			ab_src      <= nxt_ab_src;
			flag_op     <= nxt_flag_op;
		end
	end

	// one-byte opcodes end after CYC1
	a_short_op: assert property (@(posedge clk_ph2) disable iff (!rst)
		(cyc == CYC1 && !multi) |=> (cyc == CYC0));

	// no instruction runs past CYC3
	a_max_cyc: assert property (@(posedge clk_ph2) disable iff (!rst)
		(cyc == CYC3) |=> (cyc == CYC0));

endmodule

// File: alu.sv
module alu
	import isa_pkg::*;
	import ctrl_pkg::*;
(
	input  logic [data_w-1:0] sb,	// special bus
	input  logic [data_w-1:0] db,	// data bus
	input  logic [data_w-1:0] adl,	// address low bus
	input  logic              c_flag,	// status carry
	input  alu_a_e            alu_a,
	input  alu_b_e            alu_b,
	input  alu_cin_e          alu_cin,
	output logic [data_w-1:0] sum,
	output logic              carry,
	output logic              ovf	// signed overflow
);

	logic [data_w-1:0] op_a, op_b;
	logic              cin;

	always_comb begin
		case (alu_a)
			A_SB:    op_a = sb;
			A_ADL:   op_a = adl;
			default: op_a = '0;
		endcase
		case (alu_b)
			B_DB:        op_b = db;
			B_NDB:       op_b = ~db;	// subtract as add of inverse
			B_MINUS_ONE: op_b = '1;	// all ones for decrement
			default:     op_b = '0;
		endcase
		case (alu_cin)
			CIN_ONE:  cin = 1'b1;
			CIN_FLAG: cin = c_flag;
			default:  cin = 1'b0;
		endcase
	end

	assign {carry, sum} = op_a + op_b + cin;	// 9-bit binary add
	// operands agree in sign, result does not
	assign ovf = (op_a[data_w-1] == op_b[data_w-1]) && (sum[data_w-1] != op_a[data_w-1]);

endmodule

// File: ctrl_pkg.sv
package ctrl_pkg;

	//////////////////////////////////////////////////
	// sequencing
	//////////////////////////////////////////////////

	// CYC0 is always the opcode fetch (sync) cycle
	typedef enum logic [2:0] {CYC0, CYC1, CYC2, CYC3} cyc_e;

	//////////////////////////////////////////////////
	// datapath selects, registered in the decoder
	//////////////////////////////////////////////////

	// source driven on the special bus
	typedef enum logic [2:0] {SB_NONE, SB_AC, SB_X, SB_Y, SB_ADD} sb_src_e;

	// register loaded with the ALU result
	typedef enum logic [1:0] {DST_NONE, DST_AC, DST_X, DST_Y} sb_dst_e;

	// ALU A operand
	typedef enum logic [1:0] {A_ZERO, A_SB, A_ADL} alu_a_e;

	// ALU B operand, NDB for subtract and MINUS_ONE for decrement
	typedef enum logic [1:0] {B_ZERO, B_DB, B_NDB, B_MINUS_ONE} alu_b_e;

	// ALU carry in
	typedef enum logic [1:0] {CIN_ZERO, CIN_ONE, CIN_FLAG} alu_cin_e;

	// address bus source
	typedef enum logic [1:0] {AB_PC, AB_ZPG, AB_ABS} ab_src_e;

	// status flag update
	typedef enum logic [1:0] {FL_NONE, FL_NZ, FL_NZCV, FL_IR5_C} flag_op_e;

endpackage

// File: isa_pkg.sv
package isa_pkg;

	//////////////////////////////////////////////////
	// widths and fixed addresses
	//////////////////////////////////////////////////

	localparam int data_w = 8;	// data byte
	localparam int addr_w = 16;	// address bus

	localparam logic [addr_w-1:0] reset_pc = 16'h0200;	// first opcode fetch after reset

	// status byte bit positions, other bits read as zero
	localparam int flag_n = 7;	// negative
	localparam int flag_v = 6;	// signed overflow
	localparam int flag_z = 1;	// zero result
	localparam int flag_c = 0;	// carry / not borrow

	//////////////////////////////////////////////////
	// opcodes, standard encodings
	//////////////////////////////////////////////////

	typedef enum logic [data_w-1:0] {
		ADC_IMM = 8'h69,	// A + #imm + C
		SBC_IMM = 8'he9,	// A + ~#imm + C
		ADC_ZPG = 8'h65,	// A + [00,zp] + C
		ADC_ABS = 8'h6d,	// A + [hi,lo] + C
		SEC     = 8'h38,	// C = 1
		CLC     = 8'h18,	// C = 0
		INX     = 8'he8,
		INY     = 8'hc8,
		DEX     = 8'hca,
		DEY     = 8'h88,
		TAX     = 8'haa,
		TXA     = 8'h8a,
		TAY     = 8'ha8,
		TYA     = 8'h98
	} opcode_e;

endpackage
